// File: hw/branch_predictor.sv
// =========================================================================
// Branch predictor for the fetch stage
// Direct mapped BTB with same-cycle lookup, plus the speculative RAS
// pointer that follows predicted calls and returns
// =========================================================================

`include "frontend_macros.svh"

module branch_predictor
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        reset_i,
	input  addr_t       lookup_pc_i,
	input  logic        lookup_valid_i,
	input  btb_update_t train_i,
	input  logic        train_valid_i,
	input  logic        restore_i,
	input  ras_ptr_t    restore_ptr_i,
	output br_info_t    br_info_o
);

	// =====================================================================
	// Address split
	// =====================================================================

	// Slot number sits right above the word offset
	localparam int SLOT_LSB = 2;
	localparam int IDX_LSB  = SLOT_LSB + $bits(slot_idx_t);
	localparam int IDX_W    = $clog2(`BTB_ENTRIES);
	localparam int TAG_LSB  = IDX_LSB + IDX_W;
	localparam int TAG_W    = $bits(addr_t) - TAG_LSB;

	// Last legal RAS pointer value
	localparam ras_ptr_t RAS_LAST = ras_ptr_t'(`RAS_STACK_DEPTH - 1);

	typedef logic [IDX_W-1:0] btb_idx_t;
	typedef logic [TAG_W-1:0] btb_tag_t;

	// BTB storage
	logic [`BTB_ENTRIES-1:0] btb_valid;
	btb_tag_t                btb_tag    [`BTB_ENTRIES];
	slot_idx_t               btb_slot   [`BTB_ENTRIES];
	addr_t                   btb_target [`BTB_ENTRIES];
	br_type_t                btb_type   [`BTB_ENTRIES];

	// Lookup side
	btb_idx_t  lookup_idx;
	btb_tag_t  lookup_tag;
	logic      lookup_hit;

	// Training side
	btb_idx_t  train_idx;
	btb_tag_t  train_tag;
	slot_idx_t train_slot;

	// Speculative RAS pointer
	ras_ptr_t  ras_ptr_q;
	logic      ras_push;
	logic      ras_pop;

	assign lookup_idx = lookup_pc_i[IDX_LSB +: IDX_W];
	assign lookup_tag = lookup_pc_i[TAG_LSB +: TAG_W];

	assign train_idx  = train_i.pc[IDX_LSB +: IDX_W];
	assign train_tag  = train_i.pc[TAG_LSB +: TAG_W];
	// Which slot of its group the trained branch sits in
	assign train_slot = train_i.pc[SLOT_LSB +: $bits(slot_idx_t)];

	// =====================================================================
	// BTB training
	// =====================================================================

	// Valid bits, cleared by reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			btb_valid <= '0;
		end else if (train_valid_i) begin
			btb_valid[train_idx] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (train_valid_i) begin
			btb_tag[train_idx]    <= train_tag;
			btb_slot[train_idx]   <= train_slot;
			btb_target[train_idx] <= train_i.target;
			btb_type[train_idx]   <= train_i.br_type;
		end
	end

	// =====================================================================
	// Lookup
	// =====================================================================

	// Reads the old contents when training hits the same entry
	assign lookup_hit = btb_valid[lookup_idx] && (btb_tag[lookup_idx] == lookup_tag);

	always_comb begin
		// No direction counters, a hit always means taken
		br_info_o.taken   = lookup_hit;
		br_info_o.br_idx  = btb_slot[lookup_idx];
		br_info_o.target  = btb_target[lookup_idx];
		br_info_o.br_type = btb_type[lookup_idx];
		// Snapshot before this group moves the pointer
		br_info_o.ras_ptr = ras_ptr_q;
	end

	// =====================================================================
	// Speculative RAS pointer
	// =====================================================================

	// Only a valid group with a taken prediction moves it
	assign ras_push = lookup_valid_i && lookup_hit && (btb_type[lookup_idx] == `BR_CALL);
	assign ras_pop  = lookup_valid_i && lookup_hit && (btb_type[lookup_idx] == `BR_RET);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ras_ptr_q <= '0;
		end else if (restore_i) begin
			// Redirect wins over a group in the same cycle
			ras_ptr_q <= restore_ptr_i;
		end else if (ras_push) begin
			ras_ptr_q <= (ras_ptr_q == RAS_LAST) ? '0 : ras_ptr_q + 1'b1;
		end else if (ras_pop) begin
			ras_ptr_q <= (ras_ptr_q == '0) ? RAS_LAST : ras_ptr_q - 1'b1;
		end
	end

endmodule : branch_predictor

// File: hw/fetch_precheck_top.sv
// =========================================================================
// Fetch pre-check slice top level
// Pre-decode and BTB lookup side by side feeding the registered checker,
// whose redirect restores the speculative RAS pointer
// =========================================================================

module fetch_precheck_top
	import frontend_pkg::*;
(
	input  logic         clk,
	input  logic         reset_i,
	input  fetch_group_t group_i,
	input  logic         fetch_valid_i,
	input  btb_update_t  train_i,
	input  logic         train_valid_i,
	output precheck_t    result_o
);

	// Control-transfer flags per slot
	slot_mask_t is_branch;

	// Prediction for the current group
	br_info_t   br_info;

	// =====================================================================
	// Pre-decode
	// =====================================================================

	pre_decoder u_pre_decoder (
		.group_i     (group_i),
		.is_branch_o (is_branch)
	);

	// =====================================================================
	// Prediction
	// =====================================================================

	// Restore comes straight from the registered result
	branch_predictor u_branch_predictor (
		.clk            (clk),
		.reset_i        (reset_i),
		.lookup_pc_i    (group_i.pc),
		.lookup_valid_i (fetch_valid_i),
		.train_i        (train_i),
		.train_valid_i  (train_valid_i),
		.restore_i      (result_o.redirect),
		.restore_ptr_i  (result_o.ras_ptr),
		.br_info_o      (br_info)
	);

	// =====================================================================
	// Check and register
	// =====================================================================

	pre_checker u_pre_checker (
		.clk           (clk),
		.reset_i       (reset_i),
		.group_i       (group_i),
		.fetch_valid_i (fetch_valid_i),
		.is_branch_i   (is_branch),
		.br_info_i     (br_info),
		.result_o      (result_o)
	);

endmodule : fetch_precheck_top

// File: hw/frontend_macros.svh
// =========================================================================
// Front end build constants
// Fetch width, RAS and BTB sizes and the branch-kind encodings
// =========================================================================

`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Instruction slots in one aligned fetch group
`define FETCH_WIDTH 2

// Return address stack depth
// Only the pointer is modelled in this slice
`define RAS_STACK_DEPTH 8

// Branch target buffer entries, direct mapped
`define BTB_ENTRIES 16

// =========================================================================
// Branch kinds stored in the BTB
// =========================================================================

// Conditional branch
`define BR_COND 2'd0
// Call, pushes the RAS pointer
`define BR_CALL 2'd1
// Return, pops the RAS pointer
`define BR_RET 2'd2
// Plain unconditional jump
`define BR_JUMP 2'd3

`endif

// File: hw/frontend_pkg.sv
// =========================================================================
// Front end shared types
// Address and instruction vectors plus the structs passed between blocks
// =========================================================================

`include "frontend_macros.svh"

package frontend_pkg;

	// Byte address
	typedef logic [31:0] addr_t;
	// Raw RV32 instruction word
	typedef logic [31:0] inst_t;
	// Speculative RAS pointer
	typedef logic [$clog2(`RAS_STACK_DEPTH)-1:0] ras_ptr_t;
	// Slot number inside a fetch group
	typedef logic [$clog2(`FETCH_WIDTH)-1:0] slot_idx_t;
	// Branch kind, see BR_* codes
	typedef logic [1:0] br_type_t;
	// One bit per slot
	typedef logic [`FETCH_WIDTH-1:0] slot_mask_t;

	// =====================================================================
	// Structs
	// =====================================================================

	// Fetch group as delivered by the instruction fetch
	typedef struct packed {
		// Group base, bits 2..0 are zero
		addr_t                    pc;
		inst_t [`FETCH_WIDTH-1:0] inst;
		slot_mask_t               valid;
	} fetch_group_t;

	// Prediction for one fetch group
	typedef struct packed {
		logic      taken;
		slot_idx_t br_idx;
		addr_t     target;
		br_type_t  br_type;
		// Pointer as it was before this group
		ras_ptr_t  ras_ptr;
	} br_info_t;

	// BTB training request
	typedef struct packed {
		// Address of the branch itself
		addr_t    pc;
		addr_t    target;
		br_type_t br_type;
	} btb_update_t;

	// Registered pre-check result
	typedef struct packed {
		logic       redirect;
		addr_t      pc;
		addr_t      target;
		ras_ptr_t   ras_ptr;
		slot_mask_t valid;
	} precheck_t;

endpackage : frontend_pkg

// File: hw/pre_checker.sv
// =========================================================================
// Fetch stage prediction pre-check
// Catches taken predictions on non-branch slots and registers a redirect
// to the fall-through address with the slot valid mask squashed
// =========================================================================

`include "frontend_macros.svh"

module pre_checker
	import frontend_pkg::*;
(
	input  logic         clk,
	input  logic         reset_i,
	input  fetch_group_t group_i,
	input  logic         fetch_valid_i,
	input  slot_mask_t   is_branch_i,
	input  br_info_t     br_info_i,
	output precheck_t    result_o
);

	// Address of every slot in the group
	addr_t [`FETCH_WIDTH-1:0] slot_pc;

	// Slot that the predictor wrongly marked as a taken branch
	slot_mask_t miss;

	// Next and current result
	precheck_t result_d;
	precheck_t result_q;

	always_comb begin
		for (int i = 0; i < `FETCH_WIDTH; i++) begin
			// Four bytes per slot from the group base
			slot_pc[i] = group_i.pc + addr_t'(4 * i);
		end
	end

	// =====================================================================
	// Miss detection
	// =====================================================================

	always_comb begin
		for (int i = 0; i < `FETCH_WIDTH; i++) begin
			miss[i] = fetch_valid_i && br_info_i.taken &&
				(br_info_i.br_idx == slot_idx_t'(i)) &&
				group_i.valid[i] && !is_branch_i[i];
		end
	end

	// =====================================================================
	// Result selection
	// =====================================================================

	always_comb begin
		// Fields stay zero without a miss
		result_d          = '0;
		result_d.redirect = |miss;
		// Nothing valid on an idle cycle
		result_d.valid    = fetch_valid_i ? group_i.valid : '0;

		for (int i = 0; i < `FETCH_WIDTH; i++) begin
			if (miss[i]) begin
				// Resume at the instruction after the false branch
				result_d.pc      = slot_pc[i];
				result_d.target  = slot_pc[i] + 32'd4;
				result_d.ras_ptr = br_info_i.ras_ptr;
			end
		end

		// Squash the slot following a miss
		for (int i = 1; i < `FETCH_WIDTH; i++) begin
			result_d.valid[i] = result_d.valid[i] & ~miss[i-1];
		end
	end

	// One cycle of latency to the output
	always_ff @(posedge clk) begin
		if (reset_i) begin
			result_q <= '0;
		end else begin
			result_q <= result_d;
		end
	end

	assign result_o = result_q;

endmodule : pre_checker

// File: hw/pre_decoder.sv
// =========================================================================
// Fetch group pre-decoder
// Flags JAL, JALR and conditional branches in every slot by major opcode
// =========================================================================

`include "frontend_macros.svh"

module pre_decoder
	import frontend_pkg::*;
(
	input  fetch_group_t group_i,
	output slot_mask_t   is_branch_o
);

	// RV32 major opcodes of the control-transfer class
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	// Major opcode of each slot
	logic [`FETCH_WIDTH-1:0][6:0] opcode;

	// Per-class hit masks
	slot_mask_t is_cond;
	slot_mask_t is_jal;
	slot_mask_t is_jalr;

	// =====================================================================
	// Opcode extraction
	// =====================================================================

	always_comb begin
		for (int i = 0; i < `FETCH_WIDTH; i++) begin
			// Low seven bits hold the major opcode
			opcode[i] = group_i.inst[i][6:0];
		end
	end

	// =====================================================================
	// Classification
	// =====================================================================

	always_comb begin
		for (int i = 0; i < `FETCH_WIDTH; i++) begin
			// BEQ through BGEU share one opcode
			is_cond[i] = (opcode[i] == OPC_BRANCH);
			// Direct jump, also used for calls
			is_jal[i]  = (opcode[i] == OPC_JAL);
			// Indirect jump, calls and returns
			is_jalr[i] = (opcode[i] == OPC_JALR);
		end
	end

	// Any control transfer counts as a branch here
	// Slot valid bits are left to the pre-checker
	assign is_branch_o = is_cond | is_jal | is_jalr;

endmodule : pre_decoder

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch pre-check testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_fetch_precheck -f verilog.f -o Vtb_fetch_precheck

# Keep the output even when the simulation stops with an error
out=$(./obj_dir/Vtb_fetch_precheck 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "NO ERRORS"; then
	exit 0
fi
exit 1

// File: sim/tb_fetch_precheck.sv
// ============================================================================
// Testbench for the fetch pre-check slice
// Directed tests and xorshift groups checked against a BTB and RAS model
// ============================================================================

`include "frontend_macros.svh"

module tb_fetch_precheck
	import frontend_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Tests need about 300 cycles, ample headroom
	localparam int unsigned MAX_CYCLES = 2000;
	// addi x1, x1, 1 and two control transfers
	localparam inst_t ALU_WORD = 32'h0010_8093;
	localparam inst_t JAL_WORD = 32'h0080_00ef;
	localparam inst_t BEQ_WORD = 32'h0000_0463;

	logic         clk;
	logic         reset_i;
	fetch_group_t group_i;
	logic         fetch_valid_i;
	btb_update_t  train_i;
	logic         train_valid_i;
	precheck_t    result_o;

	// Model of BTB entries and the speculative pointer
	logic [`BTB_ENTRIES-1:0] m_valid;
	logic [24:0]             m_tag  [`BTB_ENTRIES];
	slot_idx_t               m_slot [`BTB_ENTRIES];
	br_type_t                m_type [`BTB_ENTRIES];
	ras_ptr_t                m_ptr;
	// What result_o should hold since the last rising edge
	precheck_t               exp_out;

	string       test_name;
	logic [31:0] rng_state;
	int unsigned cycle_count = 0;

	fetch_precheck_top dut (
		.clk           (clk),
		.reset_i       (reset_i),
		.group_i       (group_i),
		.fetch_valid_i (fetch_valid_i),
		.train_i       (train_i),
		.train_valid_i (train_valid_i),
		.result_o      (result_o)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			fail_run("Timeout, the simulation ran past its cycle limit");
		end
	end

	// ========================================================================
	// Reporting and compare tasks
	// ========================================================================

	task automatic fail_run(string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_result(precheck_t exp, precheck_t act);
		if (act !== exp) begin
			fail_run($sformatf("ERR %s: expected %h actual %h", test_name, exp, act));
		end
	endtask

	task automatic check_ptr(ras_ptr_t exp, ras_ptr_t act);
		if (act !== exp) begin
			fail_run($sformatf("ERR %s: expected ras_ptr %0d actual %0d", test_name, exp, act));
		end
	endtask

	// ========================================================================
	// Stimulus helpers and reference model
	// ========================================================================

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// JAL, JALR or BRANCH opcode
	function automatic logic is_branch_word(inst_t w);
		return (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100111) || (w[6:0] == 7'b1100011);
	endfunction

	// Random word, a control transfer or one of four plain opcodes
	function automatic inst_t random_word(logic make_branch);
		logic [31:0] r;
		logic [6:0]  opc;
		r = next_random();
		case ({make_branch, r[1:0]})
			3'b100:  opc = 7'b1100011;
			3'b101:  opc = 7'b1100111;
			3'b110,
			3'b111:  opc = 7'b1101111;
			3'b000:  opc = 7'b0010011;
			3'b001:  opc = 7'b0110011;
			3'b010:  opc = 7'b0000011;
			default: opc = 7'b0100011;
		endcase
		return {r[31:7], opc};
	endfunction

	// Index from pc bits 6..3, tag from 31..7
	function automatic logic btb_hit(addr_t pc);
		return m_valid[pc[6:3]] && (m_tag[pc[6:3]] == pc[31:7]);
	endfunction

	// Pointer after a taken prediction of the given kind, wraps at the depth
	function automatic ras_ptr_t ras_step(ras_ptr_t p, br_type_t kind);
		if (kind == `BR_CALL) begin
			return ras_ptr_t'((int'(p) + 1) % `RAS_STACK_DEPTH);
		end
		if (kind == `BR_RET) begin
			return ras_ptr_t'((int'(p) + `RAS_STACK_DEPTH - 1) % `RAS_STACK_DEPTH);
		end
		return p;
	endfunction

	function automatic precheck_t expected_result(fetch_group_t g, logic fv);
		precheck_t r;
		slot_idx_t s;
		addr_t     spc;
		r = '0;
		s = m_slot[g.pc[6:3]];
		if (fv) begin
			r.valid = g.valid;
		end
		if (fv && btb_hit(g.pc) && g.valid[s] && !is_branch_word(g.inst[s])) begin
			spc       = g.pc + (s ? 32'd4 : 32'd0);
			r.redirect = 1'b1;
			r.pc       = spc;
			r.target   = spc + 32'd4;
			r.ras_ptr  = m_ptr;
			// Later slot squashed
			if (s == 1'b0) begin
				r.valid[1] = 1'b0;
			end
		end
		return r;
	endfunction

	// One cycle, check the last result, then drive and advance the model
	task automatic run_cycle(fetch_group_t g, logic fv, btb_update_t t, logic tv);
		precheck_t next_exp;
		@(negedge clk);
		check_result(exp_out, result_o);
		group_i       = g;
		fetch_valid_i = fv;
		train_i       = t;
		train_valid_i = tv;
		next_exp      = expected_result(g, fv);
		// Restore from a redirect beats the current group
		if (exp_out.redirect) begin
			m_ptr = exp_out.ras_ptr;
		end else if (fv && btb_hit(g.pc)) begin
			m_ptr = ras_step(m_ptr, m_type[g.pc[6:3]]);
		end
		// Training lands after this cycle's lookup
		if (tv) begin
			m_valid[t.pc[6:3]] = 1'b1;
			m_tag[t.pc[6:3]]   = t.pc[31:7];
			m_slot[t.pc[6:3]]  = t.pc[2];
			m_type[t.pc[6:3]]  = t.br_type;
		end
		exp_out = next_exp;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_i       = 1'b1;
		group_i       = '0;
		fetch_valid_i = 1'b0;
		train_i       = '0;
		train_valid_i = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		m_valid = '0;
		m_ptr   = '0;
		exp_out = '0;
	endtask

	task automatic idle_cycle();
		run_cycle('0, 1'b0, '0, 1'b0);
	endtask

	task automatic train_entry(addr_t pc, addr_t target, br_type_t kind);
		btb_update_t t;
		t.pc      = pc;
		t.target  = target;
		t.br_type = kind;
		run_cycle('0, 1'b0, t, 1'b1);
	endtask

	task automatic present_group(addr_t pc, inst_t i0, inst_t i1, slot_mask_t v);
		fetch_group_t g;
		g.pc      = pc;
		g.inst[0] = i0;
		g.inst[1] = i1;
		g.valid   = v;
		run_cycle(g, 1'b1, '0, 1'b0);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_reset();
		test_name = "reset";
		apply_reset();
		repeat (3) idle_cycle();
		check_result('0, result_o);
	endtask

	task automatic test_predicted_branch();
		precheck_t e;
		test_name = "predicted_branch";
		apply_reset();
		train_entry(32'h0000_1040, 32'h0000_2000, `BR_COND);
		present_group(32'h0000_1040, BEQ_WORD, random_word(1'b0), 2'b11);
		idle_cycle();
		e       = '0;
		e.valid = 2'b11;
		check_result(e, result_o);
		// Untrained index gives a BTB miss
		present_group(32'h0000_3008, random_word(1'b0), random_word(1'b0), 2'b11);
		idle_cycle();
		check_result(e, result_o);
	endtask

	task automatic test_slot0_miss();
		precheck_t e;
		ras_ptr_t  ptr_before;
		test_name = "slot0_miss";
		apply_reset();
		train_entry(32'h0001_0010, 32'h0001_8000, `BR_JUMP);
		ptr_before = m_ptr;
		present_group(32'h0001_0010, ALU_WORD, ALU_WORD, 2'b11);
		idle_cycle();
		e          = '0;
		e.redirect = 1'b1;
		e.pc       = 32'h0001_0010;
		e.target   = 32'h0001_0014;
		e.ras_ptr  = ptr_before;
		e.valid    = 2'b01;
		check_result(e, result_o);
	endtask

	task automatic test_slot1_miss();
		precheck_t e;
		test_name = "slot1_miss";
		apply_reset();
		train_entry(32'h0002_002c, 32'h0002_4000, `BR_JUMP);
		present_group(32'h0002_0028, ALU_WORD, ALU_WORD, 2'b11);
		idle_cycle();
		e          = '0;
		e.redirect = 1'b1;
		e.pc       = 32'h0002_002c;
		e.target   = 32'h0002_0030;
		e.valid    = 2'b11;
		check_result(e, result_o);
		// Predicted slot not valid, nothing to redirect
		present_group(32'h0002_0028, ALU_WORD, ALU_WORD, 2'b01);
		idle_cycle();
		e       = '0;
		e.valid = 2'b01;
		check_result(e, result_o);
	endtask

	task automatic test_ras_pointer();
		test_name = "ras_pointer";
		apply_reset();
		for (int k = 0; k < 5; k++) begin
			train_entry(32'h0004_0000 + addr_t'(k * 8), 32'h0005_0000, `BR_CALL);
		end
		// Three real calls push the pointer to 3
		for (int k = 0; k < 3; k++) begin
			present_group(32'h0004_0000 + addr_t'(k * 8), JAL_WORD, ALU_WORD, 2'b11);
		end
		present_group(32'h0004_0018, ALU_WORD, ALU_WORD, 2'b11);
		idle_cycle();
		check_ptr(ras_ptr_t'(3), result_o.ras_ptr);
		// Restored pointer seen by the next false call
		present_group(32'h0004_0020, ALU_WORD, ALU_WORD, 2'b11);
		idle_cycle();
		check_ptr(ras_ptr_t'(3), result_o.ras_ptr);
	endtask

	task automatic test_random();
		addr_t        bases [8];
		logic [31:0]  r;
		fetch_group_t g;
		btb_update_t  t;
		test_name = "random";
		apply_reset();
		for (int k = 0; k < 8; k++) begin
			r        = next_random();
			bases[k] = r & 32'hFFFF_FFF8;
			train_entry(r & 32'hFFFF_FFFC, next_random(), r[1:0]);
		end
		// Back-to-back groups, now and then retraining in the same cycle
		for (int n = 0; n < 200; n++) begin
			r         = next_random();
			g.pc      = (r[2:0] == 3'd0) ? (next_random() & 32'hFFFF_FFF8) : bases[r[5:3]];
			g.inst[0] = random_word(r[6]);
			g.inst[1] = random_word(r[7]);
			g.valid   = r[9:8];
			t.pc      = bases[r[18:16]] + (r[19] ? 32'd4 : 32'd0);
			t.target  = next_random();
			t.br_type = r[21:20];
			run_cycle(g, r[12:10] != 3'd0, t, r[15:13] == 3'd0);
		end
		idle_cycle();
	endtask

	initial begin
		rng_state     = 32'd17966;
		reset_i       = 1'b1;
		group_i       = '0;
		fetch_valid_i = 1'b0;
		train_i       = '0;
		train_valid_i = 1'b0;
		test_reset();
		test_predicted_branch();
		test_slot0_miss();
		test_slot1_miss();
		test_ras_pointer();
		test_random();
		$display("NO ERRORS");
		$finish;
	end

endmodule : tb_fetch_precheck

// File: verilog.f
+incdir+hw
hw/frontend_pkg.sv
hw/pre_decoder.sv
hw/branch_predictor.sv
hw/pre_checker.sv
hw/fetch_precheck_top.sv
sim/tb_fetch_precheck.sv
